/* bench/qdr_cal_vectors.txt */
// One calibration per line, seven hex digits: KK m r f t e
// KK skew in tap steps, m stuck lanes, r phy_rdy, f cal_fail, t taps, e train_err
0001000
0301030
0710173
0cf10c0
0f301f5
14001f0
055015f
0a801a9
0201020

/* verilog.f */
+incdir+logic
logic/qdr_cal_pkg.sv
logic/cal_probe_if.sv
logic/opb_cal_regs.sv
logic/cal_timer.sv
logic/cal_sequencer.sv
logic/lane_checker.sv
logic/qdr_cal_top.sv
bench/qdr_cal_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal
LINTFLAGS = --lint-only -Wall --timing
TOP       = qdr_cal_tb
RTL_TOP   = qdr_cal_top
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
SOURCES   = $(wildcard logic/*.sv logic/*.svh bench/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/qdr_cal_tb.sv */
`timescale 1ns/1ns

`include "qdr_cal_config.svh"

module qdr_cal_tb;
  import qdr_cal_pkg::*;

  localparam logic [31:0] BASE = `QDR_BASEADDR;
  localparam int MAX_VEC = 32;

  logic        OPB_Clk;
  logic        rst_n;
  logic [0:31] opb_abus;
  logic [0:3]  opb_be;
  logic [0:31] opb_dbus;
  logic        opb_rnw;
  logic        opb_select;
  lane_t       q_data;
  logic [0:31] sl_dbus;
  logic        sl_xfer_ack;
  logic        qdr_reset;
  logic        dly_inc;

  logic [27:0] vectors [MAX_VEC];  // KK m r f t e, two hex digits of skew then one per field
  int          num_vec;
  int          cycles = 0;
  int          cycle_limit = 400;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  logic [7:0]  skew;
  lane_t       stuck;
  lane_t       walk;
  int          mem_pulses = 0;  // dly_inc pulses since qdr_reset
  int          reset_cnt = 0;

  qdr_cal_top dut (.*);

  initial begin
    OPB_Clk = 1'b0;
    forever #2 OPB_Clk = ~OPB_Clk;
  end

  always @(posedge OPB_Clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Regression failed");
      $finish;
    end
  end

  // Memory model watches the PHY controls mid-cycle
  always @(negedge OPB_Clk) begin
    if (qdr_reset) begin
      mem_pulses = 0;
      reset_cnt++;
    end else if (dly_inc) begin
      mem_pulses++;
    end
  end

  // Dead lanes until the skew is covered, then walking ones
  always @(posedge OPB_Clk) begin
    #1;
    q_data = (mem_pulses >= int'(skew)) ? (walk | stuck) : '0;
    walk   = {walk[`QDR_LANES-2:0], walk[`QDR_LANES-1]};
  end

  task automatic check_status(string what, logic exp_rdy, logic exp_fail,
                              logic got_rdy, logic got_fail);
    if (got_rdy !== exp_rdy || got_fail !== exp_fail) begin
      errors++;
      $display("mismatch at %0t: %s rdy/fail expected %b/%b got %b/%b", $time, what,
               exp_rdy, exp_fail, got_rdy, got_fail);
    end
  endtask

  task automatic check_taps(string what, tap_t exp, tap_t got);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  task automatic check_err(string what, lane_t exp, lane_t got);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %b got %b", $time, what, exp, got);
    end
  endtask

  task automatic check_word(string what, logic [31:0] exp, logic [31:0] got);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %h got %h", $time, what, exp, got);
    end
  endtask

  task automatic check_count(string what, int exp, int got);
    if (got != exp) begin
      errors++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, what, exp, got);
    end
  endtask

  function automatic logic [31:0] reg_addr(logic [3:0] idx);
    return BASE + {26'b0, idx, 2'b00};
  endfunction

  // One OPB transfer, lat is cycles from select to acknowledge, -1 if none
  task automatic bus_access(input logic [31:0] addr, input logic rnw,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output int lat);
    int n;
    n = 0;
    lat = -1;
    rdata = '0;
    @(posedge OPB_Clk);
    #1;
    opb_abus   = addr;
    opb_rnw    = rnw;
    opb_dbus   = rnw ? 32'h0 : wdata;
    opb_be     = 4'hF;
    opb_select = 1'b1;
    while (lat < 0 && n < 4) begin
      @(negedge OPB_Clk);
      n++;
      if (sl_xfer_ack) begin
        lat   = n - 1;
        rdata = sl_dbus;
      end
    end
    @(posedge OPB_Clk);
    #1;
    opb_select = 1'b0;
    opb_rnw    = 1'b1;
    opb_dbus   = '0;
    @(negedge OPB_Clk);
    if (sl_xfer_ack) begin
      errors++;
      $display("error at %0t: acknowledge repeated in the next cycle for %h", $time, addr);
    end
  endtask

  task automatic opb_read(input logic [31:0] addr, output logic [31:0] data);
    int lat;
    bus_access(addr, 1'b1, 32'h0, data, lat);
    check_count("read ack latency", 1, lat);
  endtask

  task automatic opb_write(input logic [31:0] addr, input logic [31:0] data);
    int lat;
    logic [31:0] unused;
    bus_access(addr, 1'b0, data, unused, lat);
    check_count("write ack latency", 1, lat);
  endtask

  task automatic finish_test(string name, int begin_err);
    tests_run++;
    if (errors == begin_err) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED", tests_run, name);
    end
  endtask

  task automatic run_reg_test();
    logic [31:0] rd;
    int lat;
    int begin_err;
    begin_err = errors;
    opb_read(reg_addr(4'd2), rd);
    check_word("idle SM_PRB", 32'hFF00_0000, rd);
    opb_read(reg_addr(4'd0), rd);
    check_word("RESET readback", 32'h0, rd);
    opb_read(reg_addr(4'd5), rd);
    check_word("unused index 5", 32'h0, rd);
    opb_read(reg_addr(4'd15), rd);
    check_word("unused index 15", 32'h0, rd);
    bus_access(`QDR_HIGHADDR + 32'h1, 1'b1, 32'h0, rd, lat);
    if (lat >= 0) begin
      errors++;
      $display("error at %0t: address above the window was acknowledged", $time);
    end
    bus_access(BASE - 32'h4, 1'b1, 32'h0, rd, lat);
    if (lat >= 0) begin
      errors++;
      $display("error at %0t: address below the window was acknowledged", $time);
    end
    finish_test("register access", begin_err);
  endtask

  task automatic run_cal_test(logic [27:0] v);
    logic [31:0] rd;
    int begin_err;
    begin_err = errors;
    skew      = v[27:20];
    stuck     = v[19:16];
    reset_cnt = 0;
    opb_write(reg_addr(4'd0), $urandom | 32'h1);
    opb_read(reg_addr(4'd1), rd);
    check_status("status after start", 1'b0, 1'b0, rd[0], rd[8]);
    do begin
      opb_read(reg_addr(4'd1), rd);
    end while (!rd[0] && !rd[8]);
    check_status("final status", v[12], v[8], rd[0], rd[8]);
    opb_read(reg_addr(4'd2), rd);
    check_taps("taps", v[7:4], rd[7:4]);
    opb_read(reg_addr(4'd3), rd);
    check_err("train_err", v[3:0], rd[3:0]);
    check_count("reset hold cycles", `QDR_RESET_CYCLES, reset_cnt);
    check_count("dly_inc pulses", int'(v[7:4]), mem_pulses);
    finish_test($sformatf("skew %0d mask %b", skew, stuck), begin_err);
  endtask

  initial begin
    rst_n      = 1'b0;
    opb_abus   = '0;
    opb_be     = '0;
    opb_dbus   = '0;
    opb_rnw    = 1'b1;
    opb_select = 1'b0;
    q_data     = '0;
    skew       = '0;
    stuck      = '0;
    walk       = lane_t'(1);
    void'($urandom(32'h1923));
    for (int i = 0; i < MAX_VEC; i++) begin
      vectors[i] = '1;  // Sentinel past the last line
    end
    $readmemh("bench/qdr_cal_vectors.txt", vectors);
    num_vec = 0;
    while (num_vec < MAX_VEC && vectors[num_vec] !== '1) begin
      num_vec++;
    end
    cycle_limit = 400 * (num_vec + 1);
    if (num_vec == 0) begin
      errors++;
      $display("error: no test vectors found in bench/qdr_cal_vectors.txt");
    end
    repeat (10) @(posedge OPB_Clk);
    #1 rst_n = 1'b1;
    run_reg_test();
    for (int t = 0; t < num_vec; t++) begin
      run_cal_test(vectors[t]);
    end
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* logic/qdr_cal_top.sv */
`timescale 1ns/1ns

`include "qdr_cal_config.svh"

module qdr_cal_top (
  input  logic               OPB_Clk,
  input  logic               rst_n,
  input  logic [0:31]        opb_abus,
  input  logic [0:3]         opb_be,
  input  logic [0:31]        opb_dbus,
  input  logic               opb_rnw,
  input  logic               opb_select,
  input  qdr_cal_pkg::lane_t q_data,
  output logic [0:31]        sl_dbus,
  output logic               sl_xfer_ack,
  output logic               qdr_reset,
  output logic               dly_inc
);
  import qdr_cal_pkg::*;

  logic                        start;
  logic                        active;
  lane_t                       err_acc;
  logic                        clear;
  logic                        train_en;
  logic                        timer_load;
  logic [`QDR_TIMER_WIDTH-1:0] timer_value;
  logic                        timer_done;

  cal_probe_if probe_bus ();

  opb_cal_regs u_regs (
    .OPB_Clk     (OPB_Clk),
    .rst_n       (rst_n),
    .opb_abus    (opb_abus),
    .opb_be      (opb_be),
    .opb_dbus    (opb_dbus),
    .opb_rnw     (opb_rnw),
    .opb_select  (opb_select),
    .sl_dbus     (sl_dbus),
    .sl_xfer_ack (sl_xfer_ack),
    .start       (start),
    .probe       (probe_bus.sink)
  );

  cal_sequencer u_seq (
    .OPB_Clk     (OPB_Clk),
    .rst_n       (rst_n),
    .start       (start),
    .active      (active),
    .err_acc     (err_acc),
    .timer_done  (timer_done),
    .timer_load  (timer_load),
    .timer_value (timer_value),
    .clear       (clear),
    .train_en    (train_en),
    .qdr_reset   (qdr_reset),
    .dly_inc     (dly_inc),
    .probe       (probe_bus.source)
  );

  cal_timer u_timer (
    .OPB_Clk    (OPB_Clk),
    .rst_n      (rst_n),
    .load       (timer_load),
    .load_value (timer_value),
    .done       (timer_done)
  );

  // Only the accumulated errors reach the sequencer
  lane_checker u_checker (
    .OPB_Clk  (OPB_Clk),
    .rst_n    (rst_n),
    .q_data   (q_data),
    .clear    (clear),
    .train_en (train_en),
    .active   (active),
    .rot_err  (),
    .err_acc  (err_acc)
  );

endmodule

/* logic/lane_checker.sv */
`timescale 1ns/1ns

module lane_checker (
  input  logic               OPB_Clk,
  input  logic               rst_n,
  input  qdr_cal_pkg::lane_t q_data,
  input  logic               clear,
  input  logic               train_en,
  output logic               active,
  output qdr_cal_pkg::lane_t rot_err,
  output qdr_cal_pkg::lane_t err_acc
);
  import qdr_cal_pkg::*;

  lane_t cur;
  lane_t prev;
  lane_t prev_rot;

  always_ff @(posedge OPB_Clk) begin
    cur  <= q_data;
    prev <= cur;
  end

  // Walking ones move up one lane per cycle
  assign prev_rot = {prev[$bits(lane_t)-2:0], prev[$bits(lane_t)-1]};
  assign rot_err  = cur ^ prev_rot;
  assign active   = (cur != '0);

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      err_acc <= '0;
    end else if (clear) begin
      err_acc <= '0;
    end else if (train_en) begin
      err_acc <= err_acc | rot_err;  // Sticky per lane
    end
  end

endmodule

/* logic/cal_sequencer.sv */
`timescale 1ns/1ns

`include "qdr_cal_config.svh"

module cal_sequencer (
  input  logic                        OPB_Clk,
  input  logic                        rst_n,
  input  logic                        start,
  input  logic                        active,
  input  qdr_cal_pkg::lane_t          err_acc,
  input  logic                        timer_done,
  output logic                        timer_load,
  output logic [`QDR_TIMER_WIDTH-1:0] timer_value,
  output logic                        clear,
  output logic                        train_en,
  output logic                        qdr_reset,
  output logic                        dly_inc,
  cal_probe_if.source                 probe
);
  import qdr_cal_pkg::*;

  localparam int WIN_W = $clog2(`QDR_ALIGN_WINDOW);
  localparam logic [`QDR_TIMER_WIDTH-1:0] RESET_LOAD  = `QDR_TIMER_WIDTH'(`QDR_RESET_CYCLES - 1);
  localparam logic [`QDR_TIMER_WIDTH-1:0] SETTLE_LOAD = `QDR_TIMER_WIDTH'(`QDR_SETTLE_CYCLES - 1);
  localparam logic [`QDR_TIMER_WIDTH-1:0] TRAIN_LOAD  = `QDR_TIMER_WIDTH'(`QDR_TRAIN_CYCLES - 1);

  cal_state_t       state;
  tap_t             taps;
  logic [WIN_W-1:0] align_cnt;
  train_idx_t       train_idx;
  logic             window_full;
  logic             taps_max;

  assign window_full = (align_cnt == WIN_W'(`QDR_ALIGN_WINDOW - 1));
  assign taps_max    = (taps == tap_t'(`QDR_MAX_TAPS));

  // Timer loads happen on the cycle a timed state is entered
  always_comb begin
    timer_load  = 1'b0;
    timer_value = '0;
    clear       = 1'b0;
    case (state)
      ST_IDLE, ST_DONE, ST_FAIL: begin
        if (start) begin
          timer_load  = 1'b1;
          timer_value = RESET_LOAD;
          clear       = 1'b1;  // Drop errors of the last run
        end
      end
      ST_ALIGN: begin
        if (active && window_full) begin
          timer_load  = 1'b1;
          timer_value = TRAIN_LOAD;
        end else if (!active && !taps_max) begin
          timer_load  = 1'b1;
          timer_value = SETTLE_LOAD;
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= ST_IDLE;
      taps      <= '0;
      align_cnt <= '0;
      train_idx <= '0;
      dly_inc   <= 1'b0;
    end else begin
      dly_inc <= 1'b0;
      case (state)
        ST_IDLE, ST_DONE, ST_FAIL: begin
          if (start) begin
            state <= ST_RESET;
            taps  <= '0;
          end
        end
        ST_RESET: begin
          if (timer_done) begin
            state     <= ST_ALIGN;
            align_cnt <= '0;
          end
        end
        ST_ALIGN: begin
          if (active) begin
            if (window_full) begin
              state     <= ST_TRAIN;
              train_idx <= '0;
            end else begin
              align_cnt <= align_cnt + 1'b1;
            end
          end else if (!taps_max) begin
            taps    <= taps + 1'b1;  // Step the delay line one tap
            dly_inc <= 1'b1;
            state   <= ST_SETTLE;
          end else begin
            state <= ST_FAIL;        // Out of taps with dead lanes
          end
        end
        ST_SETTLE: begin
          if (timer_done) begin
            state     <= ST_ALIGN;
            align_cnt <= '0;
          end
        end
        ST_TRAIN: begin
          train_idx <= train_idx + 1'b1;
          if (timer_done) begin
            state <= (err_acc == '0) ? ST_DONE : ST_FAIL;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign train_en  = (state == ST_TRAIN);
  assign qdr_reset = (state == ST_RESET);

  assign probe.state       = state;
  assign probe.taps        = taps;
  assign probe.train_index = train_idx;
  assign probe.train_err   = err_acc;
  assign probe.phy_rdy     = (state == ST_DONE);
  assign probe.cal_fail    = (state == ST_FAIL);

endmodule

/* logic/cal_timer.sv */
`timescale 1ns/1ns

`include "qdr_cal_config.svh"

// Down-counter shared by all timed phases of calibration
module cal_timer (
  input  logic                        OPB_Clk,
  input  logic                        rst_n,
  input  logic                        load,
  input  logic [`QDR_TIMER_WIDTH-1:0] load_value,
  output logic                        done
);

  logic [`QDR_TIMER_WIDTH-1:0] count;

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (load) begin
      count <= load_value;
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  // A phase loaded with N runs N+1 cycles
  assign done = (count == '0) && !load;

endmodule

/* logic/opb_cal_regs.sv */
`timescale 1ns/1ns

`include "qdr_cal_config.svh"

module opb_cal_regs (
  input  logic        OPB_Clk,
  input  logic        rst_n,
  input  logic [0:31] opb_abus,
  input  logic [0:3]  opb_be,
  input  logic [0:31] opb_dbus,
  input  logic        opb_rnw,
  input  logic        opb_select,
  output logic [0:31] sl_dbus,
  output logic        sl_xfer_ack,
  output logic        start,
  cal_probe_if.sink   probe
);
  import qdr_cal_pkg::*;

  logic [31:0] offset;
  logic        in_window;
  reg_index_t  index;
  reg_index_t  index_q;     // Word index of the access being acknowledged
  logic        start_q;

  // Byte offset from the base, then word addressing
  assign offset    = opb_abus - `QDR_BASEADDR;
  assign index     = reg_index_t'(offset[5:2]);
  assign in_window = opb_select &&
                     (opb_abus >= `QDR_BASEADDR) && (opb_abus <= `QDR_HIGHADDR);

  always_ff @(posedge OPB_Clk or negedge rst_n) begin
    if (!rst_n) begin
      sl_xfer_ack <= 1'b0;
      start_q     <= 1'b0;
    end else begin
      // Never two acknowledges back to back
      sl_xfer_ack <= in_window && !sl_xfer_ack;
      start_q     <= in_window && !sl_xfer_ack && !opb_rnw &&
                     opb_be[3] && opb_dbus[31] && (index == REG_RESET);
    end
  end

  always_ff @(posedge OPB_Clk) begin
    if (in_window && !sl_xfer_ack) begin
      index_q <= index;
    end
  end

  assign start = start_q;  // Lines up with the acknowledge cycle

  // Read data straight from the live probes, bit 31 is the LSB
  always_comb begin
    sl_dbus = '0;
    if (sl_xfer_ack) begin
      case (index_q)
        REG_STATUS: begin
          sl_dbus = {16'b0, 7'b0, probe.cal_fail, 7'b0, probe.phy_rdy};
        end
        REG_SM_PRB: begin
          sl_dbus = {8'hFF, 12'b0, probe.state, probe.taps, probe.train_index};
        end
        REG_SM_ERR: begin
          sl_dbus = {8'hFF, 20'b0, probe.train_err};
        end
        default: begin
          sl_dbus = '0;  // RESET is write only
        end
      endcase
    end
  end

endmodule

/* logic/cal_probe_if.sv */
`timescale 1ns/1ns

// Status from the sequencer to the register slave
interface cal_probe_if;
  import qdr_cal_pkg::*;

  cal_state_t state;
  tap_t       taps;
  train_idx_t train_index;
  lane_t      train_err;
  logic       cal_fail;
  logic       phy_rdy;

  modport source (
    output state, taps, train_index, train_err, cal_fail, phy_rdy
  );

  modport sink (
    input state, taps, train_index, train_err, cal_fail, phy_rdy
  );

endinterface

/* logic/qdr_cal_pkg.sv */
`include "qdr_cal_config.svh"

package qdr_cal_pkg;

  // Sequencer state, 4 bits wide to fill its probe field
  typedef enum logic [3:0] {
    ST_IDLE   = 4'd0,
    ST_RESET  = 4'd1,
    ST_ALIGN  = 4'd2,
    ST_SETTLE = 4'd3,
    ST_TRAIN  = 4'd4,
    ST_DONE   = 4'd5,
    ST_FAIL   = 4'd6
  } cal_state_t;

  // Word index inside the register window
  typedef enum logic [3:0] {
    REG_RESET  = 4'd0,
    REG_STATUS = 4'd1,
    REG_SM_PRB = 4'd2,
    REG_SM_ERR = 4'd3
  } reg_index_t;

  typedef logic [`QDR_LANES-1:0] lane_t;  // One sample across all lanes
  typedef logic [3:0]            tap_t;
  typedef logic [3:0]            train_idx_t;

endpackage

/* logic/qdr_cal_config.svh */
`ifndef QDR_CAL_CONFIG_SVH
`define QDR_CAL_CONFIG_SVH

// OPB window of the register slave, 16 words
`define QDR_BASEADDR      32'h8000_0000
`define QDR_HIGHADDR      32'h8000_003F

`define QDR_LANES         4
`define QDR_MAX_TAPS      15

// Calibration timing in OPB_Clk cycles
`define QDR_RESET_CYCLES  32
`define QDR_SETTLE_CYCLES 4
`define QDR_ALIGN_WINDOW  8   // Clean samples before training
`define QDR_TRAIN_CYCLES  16

`define QDR_TIMER_WIDTH   6

`endif
